//--- build.f
common/vregpack_pkg.sv
vregpack/vregpack_narrow.sv
vregpack/vregpack_shift_buffer.sv
vregpack/vregpack_stage_ctrl.sv
vregpack/vregpack_top.sv
testbench/vregpack_tb_clkgen.sv
testbench/vregpack_tb.sv

//--- Bender.yml
package:
  name: vregpack

sources:
  # shared package first
  - common/vregpack_pkg.sv
  # packer RTL
  - vregpack/vregpack_narrow.sv
  - vregpack/vregpack_shift_buffer.sv
  - vregpack/vregpack_stage_ctrl.sv
  - vregpack/vregpack_top.sv
  # testbench
  - target: test
    files:
      - testbench/vregpack_tb_clkgen.sv
      - testbench/vregpack_tb.sv

//--- testbench/vregpack_tb.sv
// --------------------------------------------------
// vregpack testbench
// drives pipeline items and hazards, models the
// packing buffers and checks the DUT with assertions
// --------------------------------------------------
`timescale 1ns/1ps

module vregpack_tb import vregpack_pkg::*; ();

    localparam int MAX_CYCLES = 5000;  // all phases take a few hundred cycles

    logic                            clk;
    logic                            rst_n;
    logic                            pipe_valid;
    logic                            pipe_ready;
    pack_in_t                        pipe_in;
    logic [VREG_CNT-1:0]             pending_reads;
    instr_state_e [INSTR_ID_CNT-1:0] instr_state;
    logic                            vreg_wr_valid;
    logic                            vreg_wr_ready;
    vreg_wr_t                        vreg_wr;
    logic                            done_valid;
    logic [INSTR_ID_W-1:0]           done_id;

    // reference model of the stage and the buffers
    logic                  held_valid;
    logic [INSTR_ID_W-1:0] held_id;
    logic [VADDR_W-1:0]    held_vaddr;
    logic                  held_store;
    logic                  held_done;
    logic                  held_stall;
    logic                  held_killed;
    logic                  exp_ready;
    logic                  exp_wr_valid;
    logic                  exp_done;
    logic                  xfer;
    logic                  seen_xfer;
    logic [VPORT_W-1:0]    model_data;
    logic [VPORT_BE_W-1:0] model_be;
    logic [INSTR_ID_W-1:0] done_fifo [256];  // IDs in acceptance order
    logic [7:0]            done_wr;
    logic [7:0]            done_rd;
    logic [INSTR_ID_W-1:0] done_head;
    logic                  random_bp;
    int                    cycle_cnt = 0;

    vregpack_tb_clkgen u_clkgen (.clk_o(clk), .rst_no(rst_n));

    vregpack_top UUT (
        .clk_i              (clk),
        .async_rst_ni       (rst_n),
        .pipe_valid_i       (pipe_valid),
        .pipe_ready_o       (pipe_ready),
        .pipe_in_i          (pipe_in),
        .pending_reads_i    (pending_reads),
        .instr_state_i      (instr_state),
        .vreg_wr_valid_o    (vreg_wr_valid),
        .vreg_wr_ready_i    (vreg_wr_ready),
        .vreg_wr_o          (vreg_wr),
        .instr_done_valid_o (done_valid),
        .instr_done_id_o    (done_id)
    );

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic mismatch_found(input string name, input logic [127:0] expv,
                                  input logic [127:0] actv);
        fail_now($sformatf("mismatch %s expected 0x%0h actual 0x%0h", name, expv, actv));
    endtask

    // half-width result by value range, {mask, data}
    function automatic logic [35:0] narrow_ref(input pack_in_t it);
        logic [63:0] w;
        logic [31:0] nd;
        logic [7:0]  m;
        longint      v;
        longint      hi;
        longint      lo;
        int          lw;
        int          nw;
        w  = it.res_data;
        m  = it.res_mask;
        nd = '0;
        lw = (it.eew == EEW_16) ? 16 : 32;
        nw = lw / 2;
        hi = it.res_flags.sig ? (longint'(1) << (nw - 1)) - 1 : (longint'(1) << nw) - 1;
        lo = it.res_flags.sig ? -(longint'(1) << (nw - 1)) : 0;
        for (int lane = 0; lane < 64 / lw; lane++) begin
            v = longint'((w >> (lane * lw)) & ((64'd1 << lw) - 1));
            if (it.res_flags.sig && v >= (longint'(1) << (lw - 1))) begin
                v = v - (longint'(1) << lw);  // two's complement value
            end
            if (it.res_flags.saturate && v > hi) begin
                v = hi;
            end else if (it.res_flags.saturate && v < lo) begin
                v = lo;
            end
            nd = nd | 32'((64'(v) & ((64'd1 << nw) - 1)) << (lane * nw));
        end
        if (it.eew == EEW_16) begin
            return {m[6], m[4], m[2], m[0], nd};
        end else begin
            return {m[4], m[4], m[0], m[0], nd};
        end
    endfunction

    // next buffer contents after one accepted result, {be, data}
    function automatic logic [143:0] pack_step(input logic [127:0] d, input logic [15:0] be,
                                               input pack_in_t it);
        logic [35:0] nr;
        logic [63:0] top;
        logic [7:0]  top_be;
        logic [63:0] low;
        logic [7:0]  low_be;
        nr = narrow_ref(it);
        top    = it.res_flags.narrow ? {nr[31:0], d[127:96]} : it.res_data;
        top_be = it.res_flags.narrow ? {nr[35:32], be[15:12]} : it.res_mask;
        low    = it.res_flags.shift ? d[127:64] : d[63:0];
        low_be = it.res_flags.shift ? be[15:8] : be[7:0];
        return {top_be, low_be, top, low};
    endfunction

    always_comb begin
        held_killed  = instr_state[held_id] == INSTR_KILLED;
        held_stall   = held_valid && held_store &&
                       (pending_reads[held_vaddr] || instr_state[held_id] == INSTR_SPECULATIVE);
        exp_ready    = !held_valid || (!held_stall && (!held_store || vreg_wr_ready));
        exp_wr_valid = held_valid && held_store && !held_stall && !held_killed;
        exp_done     = held_valid && held_done && exp_ready;
    end

    assign xfer      = pipe_valid && pipe_ready;
    assign done_head = done_fifo[done_rd];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
            seen_xfer  <= 1'b0;
            done_wr    <= '0;
            done_rd    <= '0;
        end else begin
            if (xfer) begin
                held_valid <= 1'b1;
                held_id    <= pipe_in.instr_id;
                held_vaddr <= pipe_in.vaddr;
                held_store <= pipe_in.res_store;
                held_done  <= pipe_in.instr_done;
                seen_xfer  <= 1'b1;
            end else if (exp_ready) begin
                held_valid <= 1'b0;  // item left, nothing new
            end
            if (xfer && pipe_in.instr_done) begin
                done_fifo[done_wr] <= pipe_in.instr_id;
                done_wr            <= done_wr + 1'b1;
            end
            if (done_valid) begin
                done_rd <= done_rd + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (xfer && pipe_in.res_valid) begin
            {model_be, model_data} <= pack_step(model_data, model_be, pipe_in);
        end
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_xfer |-> pipe_ready && !vreg_wr_valid && !done_valid)
        else fail_now("stage is not idle after reset");
    a_ready: assert property (@(posedge clk) disable iff (!rst_n) pipe_ready == exp_ready)
        else mismatch_found("pipe_ready_o", $sampled(exp_ready), $sampled(pipe_ready));
    a_wr_valid: assert property (@(posedge clk) disable iff (!rst_n) vreg_wr_valid == exp_wr_valid)
        else mismatch_found("vreg_wr_valid_o", $sampled(exp_wr_valid), $sampled(vreg_wr_valid));
    a_done: assert property (@(posedge clk) disable iff (!rst_n) done_valid == exp_done)
        else mismatch_found("instr_done_valid_o", $sampled(exp_done), $sampled(done_valid));
    a_done_id: assert property (@(posedge clk) disable iff (!rst_n)
        done_valid |-> done_id == done_head)
        else mismatch_found("instr_done_id_o", $sampled(done_head), $sampled(done_id));
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        vreg_wr_valid |-> vreg_wr.data === model_data)
        else mismatch_found("vreg_wr_o.data", $sampled(model_data), $sampled(vreg_wr.data));
    a_be: assert property (@(posedge clk) disable iff (!rst_n)
        vreg_wr_valid |-> vreg_wr.be === model_be)
        else mismatch_found("vreg_wr_o.be", $sampled(model_be), $sampled(vreg_wr.be));
    a_addr: assert property (@(posedge clk) disable iff (!rst_n)
        vreg_wr_valid |-> vreg_wr.addr == held_vaddr)
        else mismatch_found("vreg_wr_o.addr", $sampled(held_vaddr), $sampled(vreg_wr.addr));
    a_hold: assert property (@(posedge clk) disable iff (!rst_n) !pipe_ready |=> $stable(vreg_wr))
        else fail_now("write payload changed while the stage was blocked");

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == MAX_CYCLES) begin
            fail_now($sformatf("timeout, run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // random write port back-pressure
    always begin
        @(posedge clk);
        #1;
        if (random_bp) begin
            vreg_wr_ready = 1'($urandom_range(0, 1));
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // returns just after the edge where ready was high
    task automatic wait_ready();
        logic rdy;
        do begin
            @(negedge clk);
            rdy = pipe_ready;
            next_cycle();
        end while (!rdy);
    endtask

    task automatic send_item(input logic [2:0] id, input eew_e eew, input logic [4:0] vaddr,
                             input logic store, input logic [3:0] flags,
                             input logic [63:0] data, input logic [7:0] mask,
                             input logic done);
        // field order of pack_in_t, flags are {shift, narrow, saturate, sig}
        pipe_in    = {id, eew, vaddr, store, 1'b1, flags, data, mask, done};
        pipe_valid = 1'b1;
        wait_ready();
        pipe_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(80));
        pipe_valid    = 1'b0;
        pipe_in       = '0;
        pending_reads = '0;
        vreg_wr_ready = 1'b1;
        random_bp     = 1'b0;
        for (int i = 0; i < INSTR_ID_CNT; i++) begin
            instr_state[i] = INSTR_COMMITTED;
        end
        @(posedge rst_n);
        repeat (3) next_cycle();

        // full width, two shifts then a store
        send_item(3'd0, EEW_8, 5'd1, 1'b0, 4'b1000, 64'h0123_4567_89ab_cdef, 8'hff, 1'b0);
        send_item(3'd0, EEW_8, 5'd1, 1'b0, 4'b1000, 64'hfedc_ba98_7654_3210, 8'h0f, 1'b0);
        send_item(3'd0, EEW_8, 5'd1, 1'b1, 4'b1000, 64'h1111_2222_3333_4444, 8'hf0, 1'b1);

        // narrowing with overflowing lanes
        send_item(3'd1, EEW_16, 5'd2, 1'b0, 4'b0111, 64'h0123_ff80_8000_007f, 8'hff, 1'b0);
        send_item(3'd1, EEW_16, 5'd2, 1'b1, 4'b1110, 64'h00ff_0100_8000_0012, 8'h55, 1'b0);
        send_item(3'd1, EEW_32, 5'd2, 1'b0, 4'b0111, 64'h8000_0000_0001_2345, 8'hf0, 1'b0);
        send_item(3'd1, EEW_16, 5'd2, 1'b0, 4'b1100, 64'h1234_5678_9abc_def0, 8'h33, 1'b0);
        send_item(3'd1, EEW_32, 5'd2, 1'b1, 4'b0110, 64'h0000_1234_0001_0000, 8'h11, 1'b1);

        // hazards hold the store
        pending_reads[7] = 1'b1;
        send_item(3'd2, EEW_8, 5'd7, 1'b1, 4'b1000, {$urandom, $urandom}, 8'hff, 1'b1);
        repeat (4) next_cycle();
        pending_reads[7] = 1'b0;
        wait_ready();
        instr_state[3] = INSTR_SPECULATIVE;
        send_item(3'd3, EEW_8, 5'd8, 1'b1, 4'b1000, {$urandom, $urandom}, 8'hff, 1'b1);
        repeat (4) next_cycle();
        instr_state[3] = INSTR_COMMITTED;
        wait_ready();

        // killed store leaves without a write
        instr_state[4] = INSTR_KILLED;
        send_item(3'd4, EEW_8, 5'd9, 1'b1, 4'b1000, {$urandom, $urandom}, 8'hff, 1'b1);
        wait_ready();
        instr_state[4] = INSTR_COMMITTED;

        // back-pressure, then random traffic
        vreg_wr_ready = 1'b0;
        send_item(3'd5, EEW_8, 5'd10, 1'b1, 4'b1000, {$urandom, $urandom}, 8'hff, 1'b1);
        repeat (3) next_cycle();
        random_bp = 1'b1;
        for (int n = 0; n < 60; n++) begin
            send_item(3'(n), $urandom_range(0, 1) ? EEW_16 : EEW_32, 5'($urandom),
                      ($urandom_range(0, 2) == 0), 4'($urandom), {$urandom, $urandom},
                      8'($urandom), 1'($urandom));
        end
        random_bp     = 1'b0;
        vreg_wr_ready = 1'b1;
        wait_ready();
        repeat (2) next_cycle();

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- testbench/vregpack_tb_clkgen.sv
// --------------------------------------------------
// vregpack testbench clock and reset
// 10 ns clock, reset held low for the first cycles
// --------------------------------------------------
`timescale 1ns/1ps

module vregpack_tb_clkgen (
    output logic clk_o,
    output logic rst_no
);

    localparam int HALF_PERIOD = 5;  // 10 ns period
    localparam int RST_CYCLES  = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_no = 1'b1;  // release away from the edge
    end

endmodule

//--- vregpack/vregpack_top.sv
// --------------------------------------------------
// vregpack top level
// packs pipeline results into a register-wide buffer
// and writes it to the vector register file
// --------------------------------------------------
`timescale 1ns/1ps

module vregpack_top import vregpack_pkg::*; (
    input  logic                             clk_i,
    input  logic                             async_rst_ni,

    // pipeline side
    input  logic                             pipe_valid_i,
    output logic                             pipe_ready_o,
    input  pack_in_t                         pipe_in_i,

    // hazard tracker
    input  logic [VREG_CNT-1:0]              pending_reads_i,
    input  instr_state_e [INSTR_ID_CNT-1:0]  instr_state_i,

    // vreg write port
    output logic                             vreg_wr_valid_o,
    input  logic                             vreg_wr_ready_i,
    output vreg_wr_t                         vreg_wr_o,

    // instruction completion
    output logic                             instr_done_valid_o,
    output logic [INSTR_ID_W-1:0]            instr_done_id_o
);

    logic                   accept;
    logic [VADDR_W-1:0]     wr_addr;
    logic [VPORT_W-1:0]     wr_data;
    logic [VPORT_BE_W-1:0]  wr_be;
    logic [NARROW_W-1:0]    narrow_data;
    logic [NARROW_BE_W-1:0] narrow_mask;

    vregpack_stage_ctrl u_stage_ctrl (
        .clk_i              (clk_i),
        .async_rst_ni       (async_rst_ni),
        .pipe_valid_i       (pipe_valid_i),
        .pipe_ready_o       (pipe_ready_o),
        .pipe_in_i          (pipe_in_i),
        .pending_reads_i    (pending_reads_i),
        .instr_state_i      (instr_state_i),
        .vreg_wr_ready_i    (vreg_wr_ready_i),
        .vreg_wr_valid_o    (vreg_wr_valid_o),
        .wr_addr_o          (wr_addr),
        .accept_o           (accept),
        .instr_done_valid_o (instr_done_valid_o),
        .instr_done_id_o    (instr_done_id_o)
    );

    vregpack_narrow u_narrow (
        .eew_i         (pipe_in_i.eew),
        .flags_i       (pipe_in_i.res_flags),
        .data_i        (pipe_in_i.res_data),
        .mask_i        (pipe_in_i.res_mask),
        .narrow_data_o (narrow_data),
        .narrow_mask_o (narrow_mask)
    );

    vregpack_shift_buffer u_shift_buffer (
        .clk_i         (clk_i),
        .accept_i      (accept),
        .flags_i       (pipe_in_i.res_flags),
        .data_i        (pipe_in_i.res_data),
        .mask_i        (pipe_in_i.res_mask),
        .narrow_data_i (narrow_data),
        .narrow_mask_i (narrow_mask),
        .wr_data_o     (wr_data),
        .wr_be_o       (wr_be)
    );

    assign vreg_wr_o = '{addr: wr_addr, be: wr_be, data: wr_data};

endmodule

//--- vregpack/vregpack_stage_ctrl.sv
// --------------------------------------------------
// vregpack stage controller
// one-deep stage holding the item's metadata, with
// hazard stall, kill handling and done reporting
// --------------------------------------------------
`timescale 1ns/1ps

module vregpack_stage_ctrl import vregpack_pkg::*; (
    input  logic                             clk_i,
    input  logic                             async_rst_ni,
    input  logic                             pipe_valid_i,
    output logic                             pipe_ready_o,
    input  pack_in_t                         pipe_in_i,
    input  logic [VREG_CNT-1:0]              pending_reads_i,
    input  instr_state_e [INSTR_ID_CNT-1:0]  instr_state_i,
    input  logic                             vreg_wr_ready_i,
    output logic                             vreg_wr_valid_o,
    output logic [VADDR_W-1:0]               wr_addr_o,
    output logic                             accept_o,
    output logic                             instr_done_valid_o,
    output logic [INSTR_ID_W-1:0]            instr_done_id_o
);

    // metadata kept while the item sits in the stage
    typedef struct packed {
        logic [INSTR_ID_W-1:0] instr_id;
        logic [VADDR_W-1:0]    vaddr;
        logic                  res_store;
        logic                  instr_done;
    } stage_meta_t;

    logic        stage_valid_q;  // empty / holding
    stage_meta_t meta_q;
    logic        stage_ready;
    logic        stage_stall;
    logic        take;
    logic        instr_spec;
    logic        instr_killed;

    assign take = stage_ready & pipe_valid_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            stage_valid_q <= 1'b0;
        end else if (stage_ready) begin
            stage_valid_q <= pipe_valid_i;  // old item leaves, new one may enter
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            meta_q.instr_id   <= pipe_in_i.instr_id;
            meta_q.vaddr      <= pipe_in_i.vaddr;
            meta_q.res_store  <= pipe_in_i.res_store;
            meta_q.instr_done <= pipe_in_i.instr_done;
        end
    end

    // state of the held instruction
    always_comb begin
        instr_spec   = 1'b0;
        instr_killed = 1'b0;
        case (instr_state_i[meta_q.instr_id])
            INSTR_SPECULATIVE: instr_spec   = 1'b1;
            INSTR_KILLED:      instr_killed = 1'b1;
            default: ;
        endcase
    end

    // a store waits for pending reads of its target and for commit
    assign stage_stall = meta_q.res_store & (pending_reads_i[meta_q.vaddr] | instr_spec);

    assign stage_ready = ~stage_valid_q |
                         (~stage_stall & (~meta_q.res_store | vreg_wr_ready_i));

    assign pipe_ready_o = stage_ready;
    assign accept_o     = take & pipe_in_i.res_valid;  // buffer shifts only on real results

    assign vreg_wr_valid_o = stage_valid_q & meta_q.res_store & ~stage_stall & ~instr_killed;
    assign wr_addr_o       = meta_q.vaddr;

    // pulse in the cycle the item leaves
    assign instr_done_valid_o = stage_valid_q & meta_q.instr_done & stage_ready;
    assign instr_done_id_o    = meta_q.instr_id;

endmodule

//--- vregpack/vregpack_shift_buffer.sv
// --------------------------------------------------
// vregpack shift buffer
// register-wide data and byte-enable buffers filled
// from the top, one result per accepted item
// --------------------------------------------------
`timescale 1ns/1ps

module vregpack_shift_buffer import vregpack_pkg::*; (
    input  logic                   clk_i,
    input  logic                   accept_i,
    input  res_flags_t             flags_i,
    input  res_word_u              data_i,
    input  logic [RES_BE_W-1:0]    mask_i,
    input  logic [NARROW_W-1:0]    narrow_data_i,
    input  logic [NARROW_BE_W-1:0] narrow_mask_i,
    output logic [VPORT_W-1:0]     wr_data_o,
    output logic [VPORT_BE_W-1:0]  wr_be_o
);

    logic [VPORT_W-1:0]    data_q;
    logic [VPORT_BE_W-1:0] be_q;

    logic [RES_W-1:0]    top_data;
    logic [RES_BE_W-1:0] top_be;
    logic [RES_W-1:0]    low_data;
    logic [RES_BE_W-1:0] low_be;

    // new upper half
    always_comb begin
        if (flags_i.narrow) begin
            // narrowed half goes above the old top quarter
            top_data = {narrow_data_i, data_q[VPORT_W-1 -: NARROW_W]};
            top_be   = {narrow_mask_i, be_q[VPORT_BE_W-1 -: NARROW_BE_W]};
        end else begin
            top_data = data_i;
            top_be   = mask_i;
        end
    end

    // new lower half
    always_comb begin
        if (flags_i.shift) begin
            low_data = data_q[VPORT_W-1 -: RES_W];  // old upper contents move down
            low_be   = be_q[VPORT_BE_W-1 -: RES_BE_W];
        end else begin
            low_data = data_q[RES_W-1:0];
            low_be   = be_q[RES_BE_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            data_q <= {top_data, low_data};
            be_q   <= {top_be, low_be};
        end
    end

    assign wr_data_o = data_q;
    assign wr_be_o   = be_q;

endmodule

//--- vregpack/vregpack_narrow.sv
// --------------------------------------------------
// vregpack narrowing unit
// halves 16/32-bit elements of one result word, with
// optional signed or unsigned saturation
// --------------------------------------------------
`timescale 1ns/1ps

module vregpack_narrow import vregpack_pkg::*; (
    input  eew_e                   eew_i,
    input  res_flags_t             flags_i,
    input  res_word_u              data_i,
    input  logic [RES_BE_W-1:0]    mask_i,
    output logic [NARROW_W-1:0]    narrow_data_o,
    output logic [NARROW_BE_W-1:0] narrow_mask_o
);

    // 16-bit elements to 8 bits
    logic [NARROW_W-1:0]    data_h;
    logic [NARROW_BE_W-1:0] mask_h;

    always_comb begin
        logic [7:0] ext;
        for (int j = 0; j < RES_W / 16; j++) begin
            ext = {8{flags_i.sig & data_i.h16[j][7]}};  // sign or zero extension of kept byte
            data_h[8*j +: 8] = data_i.h16[j][7:0];
            mask_h[j]        = mask_i[2*j];
            if (flags_i.saturate && (data_i.h16[j][15:8] != ext)) begin
                if (flags_i.sig) begin
                    data_h[8*j +: 8] = {data_i.h16[j][15], {7{~data_i.h16[j][15]}}};
                end else begin
                    data_h[8*j +: 8] = 8'hff;
                end
            end
        end
    end

    // 32-bit elements to 16 bits
    logic [NARROW_W-1:0]    data_w;
    logic [NARROW_BE_W-1:0] mask_w;

    always_comb begin
        logic [15:0] ext;
        for (int j = 0; j < RES_W / 32; j++) begin
            ext = {16{flags_i.sig & data_i.w32[j][15]}};
            data_w[16*j +: 16] = data_i.w32[j][15:0];
            mask_w[2*j +: 2]   = {2{mask_i[4*j]}};  // both bytes of the half-width element
            if (flags_i.saturate && (data_i.w32[j][31:16] != ext)) begin
                if (flags_i.sig) begin
                    data_w[16*j +: 16] = {data_i.w32[j][31], {15{~data_i.w32[j][31]}}};
                end else begin
                    data_w[16*j +: 16] = 16'hffff;
                end
            end
        end
    end

    // select by element width, 8-bit elements cannot be narrowed
    always_comb begin
        case (eew_i)
            EEW_16: begin
                narrow_data_o = data_h;
                narrow_mask_o = mask_h;
            end
            EEW_32: begin
                narrow_data_o = data_w;
                narrow_mask_o = mask_w;
            end
            default: begin
                narrow_data_o = '0;
                narrow_mask_o = '0;
            end
        endcase
    end

endmodule

//--- common/vregpack_pkg.sv
// --------------------------------------------------
// vregpack shared definitions
// widths, enums and the structs passed between the
// pipeline, the packer and the register file port
// --------------------------------------------------
package vregpack_pkg;

    // vector register file port
    localparam int unsigned VPORT_W    = 128;
    localparam int unsigned VPORT_BE_W = VPORT_W / 8;

    // one result lane from the pipeline
    localparam int unsigned RES_W    = 64;
    localparam int unsigned RES_BE_W = RES_W / 8;

    // half-width part produced by narrowing
    localparam int unsigned NARROW_W    = RES_W / 2;
    localparam int unsigned NARROW_BE_W = RES_BE_W / 2;

    localparam int unsigned VADDR_W  = 5;
    localparam int unsigned VREG_CNT = 1 << VADDR_W;  // one pending-read bit per vreg

    localparam int unsigned INSTR_ID_W   = 3;
    localparam int unsigned INSTR_ID_CNT = 1 << INSTR_ID_W;

    // element width of the current instruction
    typedef enum logic [1:0] {
        EEW_8,
        EEW_16,
        EEW_32
    } eew_e;

    // state reported by the hazard tracker per instruction ID
    typedef enum logic [1:0] {
        INSTR_SPECULATIVE,
        INSTR_COMMITTED,
        INSTR_KILLED
    } instr_state_e;

    typedef struct packed {
        logic shift;     // move old upper half down
        logic narrow;    // result goes to half width
        logic saturate;  // clamp on narrowing overflow
        logic sig;       // signed result
    } res_flags_t;

    // same 64 bits seen as 16-bit or 32-bit elements
    typedef union packed {
        logic [RES_W/16-1:0][15:0] h16;
        logic [RES_W/32-1:0][31:0] w32;
    } res_word_u;

    // one item handed over by the execution pipeline
    typedef struct packed {
        logic [INSTR_ID_W-1:0] instr_id;
        eew_e                  eew;
        logic [VADDR_W-1:0]    vaddr;
        logic                  res_store;   // write buffer to vreg
        logic                  res_valid;   // res_data carries a result
        res_flags_t            res_flags;
        res_word_u             res_data;
        logic [RES_BE_W-1:0]   res_mask;
        logic                  instr_done;  // last item of the instruction
    } pack_in_t;

    // register file write payload
    typedef struct packed {
        logic [VADDR_W-1:0]    addr;
        logic [VPORT_BE_W-1:0] be;
        logic [VPORT_W-1:0]    data;
    } vreg_wr_t;

endpackage
